/* flist.f */
rtl/memCtrlPkg.sv
rtl/memCtrlIfs.sv
rtl/memReqArbiter.sv
rtl/memByteSequencer.sv
rtl/memWordAssembler.sv
rtl/memCtrlTop.sv
testbench/ramModel.sv
testbench/tbMemCtrl.sv

/* rtl/memByteSequencer.sv */
`timescale 1ns/100ps

module memByteSequencer import memCtrlPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_rdy,
    input  logic i_ioBufferFull,
    output logic o_memRw,
    output addrT o_memAddr,
    output byteT o_memDt,
    memReqIf.seq req,
    memByteIf.seq bus
);

    seqStateT state;
    stageT    stageQ;
    stageT    curStage;
    stageT    indexQ;
    addrT     lastAddr;
    addrT     curAddr;
    logic     advance;
    logic     isStore;
    logic     issuing;
    logic     lastStage;
    logic     writeNow;
    logic     validQ;
    logic     lastQ;

    assign advance  = i_rdy && !i_ioBufferFull;
    assign isStore  = (req.op == OP_STORE);

    // stage 0 goes out in the same cycle that start is seen
    assign issuing  = (state == SEQ_RUN) || ((state == SEQ_IDLE) && req.start);
    assign curStage = (state == SEQ_RUN) ? stageQ : '0;

    assign lastStage = ((lenT'(curStage) + lenT'(1)) == req.len);

    // base plus stage in little endian byte order
    assign curAddr  = issuing ? (req.addr + addrT'(curStage)) : lastAddr;
    assign writeNow = advance && issuing && isStore;

    // a stalled cycle repeats the last issued address so the RAM output
    // still belongs to the byte that the assembler is waiting for
    assign o_memAddr = advance ? curAddr : lastAddr;
    assign o_memRw   = writeNow ? MEM_WRITE : MEM_READ;
    assign o_memDt   = writeNow ? req.wdata[{curStage, 3'b000} +: 8] : '0;

    // stores end on their last write and reads one cycle later in drain
    assign req.finished = advance &&
                          ((state == SEQ_DRAIN) || (issuing && isStore && lastStage));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SEQ_IDLE;
            stageQ   <= '0;
            validQ   <= 1'b0;
            lastAddr <= '0;
        end else if (advance) begin
            lastAddr <= curAddr;
            // read data shows up one cycle after its address
            validQ   <= issuing && !isStore;
            case (state)
                SEQ_IDLE,
                SEQ_RUN: begin
                    if (issuing) begin
                        if (!lastStage) begin
                            state  <= SEQ_RUN;
                            stageQ <= curStage + 2'd1;
                        end else if (isStore) begin
                            state  <= SEQ_IDLE;
                        end else begin
                            state  <= SEQ_DRAIN;
                        end
                    end
                end
                SEQ_DRAIN: state <= SEQ_IDLE;
                default:   state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            indexQ <= curStage;
            lastQ  <= lastStage;
        end
    end

    assign bus.byteValid = validQ;
    assign bus.index     = indexQ;
    assign bus.last      = lastQ;
    assign bus.op        = req.op;

    // arbiter must wait for finished before a new start
    assert property (@(posedge clk) disable iff (rst)
        req.start |-> (state == SEQ_IDLE))
        else $error("start seen while the sequencer is busy");

    // a stall neither writes nor moves the RAM address
    assert property (@(posedge clk) disable iff (rst)
        !(i_rdy && !i_ioBufferFull) |->
            ((o_memRw == MEM_READ) && (o_memAddr == $past(o_memAddr))))
        else $error("RAM write or address change during a stall");

endmodule

/* rtl/memCtrlIfs.sv */
`timescale 1ns/100ps

// one latched request, arbiter to sequencer
interface memReqIf import memCtrlPkg::*; ();
    logic  start;
    memOpT op;
    addrT  addr;
    lenT   len;
    wordT  wdata;
    logic  finished;

    modport arb (
        output start,
        output op,
        output addr,
        output len,
        output wdata,
        input  finished
    );

    modport seq (
        input  start,
        input  op,
        input  addr,
        input  len,
        input  wdata,
        output finished
    );
endinterface

// returned byte marker, sequencer to assembler
interface memByteIf import memCtrlPkg::*; ();
    logic  byteValid;
    stageT index;
    logic  last;
    memOpT op;

    modport seq (
        output byteValid,
        output index,
        output last,
        output op
    );

    modport asm (
        input  byteValid,
        input  index,
        input  last,
        input  op
    );
endinterface

/* rtl/memCtrlPkg.sv */
package memCtrlPkg;

    // widths with a meaning on the processor side
    typedef logic [31:0] addrT;
    typedef logic [7:0]  byteT;
    typedef logic [31:0] wordT;

    // byte count of one request, 1, 2 or 4
    typedef logic [2:0]  lenT;

    // byte position inside a request, LSB first
    typedef logic [1:0]  stageT;

    typedef logic [1:0]  memOpT;

    localparam memOpT OP_FETCH  = 2'd0;
    localparam memOpT OP_LOAD   = 2'd1;
    localparam memOpT OP_STORE  = 2'd2;

    // level of o_memRw
    localparam logic  MEM_READ  = 1'b0;
    localparam logic  MEM_WRITE = 1'b1;

    // instruction fetches are always full words
    localparam lenT   FETCH_LEN = 3'd4;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BUSY,
        ARB_RELEASE
    } arbStateT;

    // drain covers the byte still in flight after the last read address
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DRAIN
    } seqStateT;

endpackage

/* rtl/memCtrlTop.sv */
`timescale 1ns/100ps

module memCtrlTop import memCtrlPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_rdy,
    input  logic i_ioBufferFull,

    // byte RAM port
    input  byteT i_memDt,
    output logic o_memRw,
    output addrT o_memAddr,
    output byteT o_memDt,

    // instruction fetch
    input  logic i_infEn,
    input  addrT i_infAddr,
    output logic o_infDone,
    output wordT o_infInst,

    // data access
    input  logic i_dcEn,
    input  logic i_dcStore,
    input  lenT  i_dcLen,
    input  wordT i_dcDt,
    input  addrT i_dcAddr,
    output logic o_dcDone,
    output wordT o_dcDt
);

    memReqIf  reqBus ();
    memByteIf byteBus ();

    logic storeDone;

    // store completion goes straight to the done logic
    assign storeDone = reqBus.finished && (reqBus.op == OP_STORE);

    memReqArbiter u_memReqArbiter (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_infEn        (i_infEn),
        .i_infAddr      (i_infAddr),
        .i_dcEn         (i_dcEn),
        .i_dcStore      (i_dcStore),
        .i_dcLen        (i_dcLen),
        .i_dcDt         (i_dcDt),
        .i_dcAddr       (i_dcAddr),
        .req            (reqBus.arb)
    );

    memByteSequencer u_memByteSequencer (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .o_memRw        (o_memRw),
        .o_memAddr      (o_memAddr),
        .o_memDt        (o_memDt),
        .req            (reqBus.seq),
        .bus            (byteBus.seq)
    );

    memWordAssembler u_memWordAssembler (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_memDt        (i_memDt),
        .i_storeDone    (storeDone),
        .bus            (byteBus.asm),
        .o_infDone      (o_infDone),
        .o_infInst      (o_infInst),
        .o_dcDone       (o_dcDone),
        .o_dcDt         (o_dcDt)
    );

endmodule

/* rtl/memReqArbiter.sv */
`timescale 1ns/100ps

module memReqArbiter import memCtrlPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_rdy,
    input  logic i_ioBufferFull,
    input  logic i_infEn,
    input  addrT i_infAddr,
    input  logic i_dcEn,
    input  logic i_dcStore,
    input  lenT  i_dcLen,
    input  wordT i_dcDt,
    input  addrT i_dcAddr,
    memReqIf.arb req
);

    arbStateT state;
    logic     advance;
    logic     takeDc;
    logic     takeInf;
    logic     startQ;
    memOpT    opQ;
    addrT     addrQ;
    lenT      lenQ;
    wordT     wdataQ;

    assign advance = i_rdy && !i_ioBufferFull;

    // data side wins when both enables are up
    assign takeDc  = advance && (state == ARB_IDLE) && i_dcEn;
    assign takeInf = advance && (state == ARB_IDLE) && !i_dcEn && i_infEn;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ARB_IDLE;
            startQ <= 1'b0;
            opQ    <= OP_FETCH;
        end else if (advance) begin
            startQ <= takeDc || takeInf;
            case (state)
                ARB_IDLE: begin
                    if (takeDc) begin
                        opQ   <= i_dcStore ? OP_STORE : OP_LOAD;
                        state <= ARB_BUSY;
                    end else if (takeInf) begin
                        opQ   <= OP_FETCH;
                        state <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (req.finished) begin
                        state <= ARB_RELEASE;
                    end
                end
                // one spare cycle while the requester drops its enable
                ARB_RELEASE: state <= ARB_IDLE;
                default:     state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (takeDc) begin
            addrQ  <= i_dcAddr;
            lenQ   <= i_dcLen;
            wdataQ <= i_dcDt;
        end else if (takeInf) begin
            addrQ  <= i_infAddr;
            lenQ   <= FETCH_LEN;
            wdataQ <= '0;
        end
    end

    assign req.start = startQ;
    assign req.op    = opQ;
    assign req.addr  = addrQ;
    assign req.len   = lenQ;
    assign req.wdata = wdataQ;

    // the sequencer only counts to a legal byte count
    assert property (@(posedge clk) disable iff (rst)
        takeDc |-> (i_dcLen inside {3'd1, 3'd2, 3'd4}))
        else $error("data request accepted with byte count %0d", i_dcLen);

endmodule

/* rtl/memWordAssembler.sv */
`timescale 1ns/100ps

module memWordAssembler import memCtrlPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_rdy,
    input  logic i_ioBufferFull,
    input  byteT i_memDt,
    input  logic i_storeDone,
    memByteIf.asm bus,
    output logic o_infDone,
    output wordT o_infInst,
    output logic o_dcDone,
    output wordT o_dcDt
);

    wordT wordQ;
    wordT merged;
    logic advance;
    logic capture;
    logic fetchDone;
    logic loadDone;

    assign advance = i_rdy && !i_ioBufferFull;
    assign capture = advance && bus.byteValid;

    assign fetchDone = capture && bus.last && (bus.op == OP_FETCH);
    assign loadDone  = capture && bus.last && (bus.op == OP_LOAD);

    // byte 0 starts from zero, upper lanes of short loads stay clear
    always_comb begin
        merged = (bus.index == '0) ? '0 : wordQ;
        merged[{bus.index, 3'b000} +: 8] = i_memDt;
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            wordQ <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_infDone <= 1'b0;
            o_infInst <= '0;
            o_dcDone  <= 1'b0;
            o_dcDt    <= '0;
        end else if (advance) begin
            o_infDone <= fetchDone;
            o_dcDone  <= loadDone || i_storeDone;
            if (fetchDone) begin
                o_infInst <= merged;
            end
            if (loadDone) begin
                o_dcDt <= merged;
            end else if (i_storeDone) begin
                // nothing to return for a store
                o_dcDt <= '0;
            end
        end
    end

    // one request in flight, so only one requester can be answered
    assert property (@(posedge clk) disable iff (rst)
        !(o_infDone && o_dcDone))
        else $error("fetch and data done raised together");

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tbMemCtrl -o simv \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/ramModel.sv */
`timescale 1ns/100ps

module ramModel import memCtrlPkg::*; (
    input  logic clk,
    input  logic i_we,
    input  addrT i_addr,
    input  byteT i_wdata,
    output byteT o_rdata
);

    byteT mem [0:255];

    // every address gets its own start value
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = byteT'(i * 151 + 29);
        end
    end

    // one cycle read latency over the low 8 address bits
    always @(posedge clk) begin
        if (i_we) begin
            mem[i_addr[7:0]] <= i_wdata;
        end
        o_rdata <= mem[i_addr[7:0]];
    end

endmodule

/* testbench/tbMemCtrl.sv */
`timescale 1ns/100ps

module tbMemCtrl import memCtrlPkg::*; ();

    localparam int WAIT_LIMIT = 300;

    logic clk;
    logic rst;
    logic rdy;
    logic ioBufferFull;
    byteT memRdata;
    logic memRw;
    addrT memAddr;
    byteT memWdata;
    logic infEn;
    addrT infAddr;
    logic infDone;
    wordT infInst;
    logic dcEn;
    logic dcStore;
    lenT  dcLen;
    wordT dcDt;
    addrT dcAddr;
    logic dcDone;
    wordT dcRdata;

    byteT        shadow [0:255];
    logic [31:0] lcgState;
    logic        stallMode;
    addrT        prevAddr;
    addrT        a;

    memCtrlTop u_memCtrlTop (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_memDt        (memRdata),
        .o_memRw        (memRw),
        .o_memAddr      (memAddr),
        .o_memDt        (memWdata),
        .i_infEn        (infEn),
        .i_infAddr      (infAddr),
        .o_infDone      (infDone),
        .o_infInst      (infInst),
        .i_dcEn         (dcEn),
        .i_dcStore      (dcStore),
        .i_dcLen        (dcLen),
        .i_dcDt         (dcDt),
        .i_dcAddr       (dcAddr),
        .o_dcDone       (dcDone),
        .o_dcDt         (dcRdata)
    );

    ramModel u_ram (
        .clk     (clk),
        .i_we    (memRw),
        .i_addr  (memAddr),
        .i_wdata (memWdata),
        .o_rdata (memRdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] randWord();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState ^ (lcgState >> 16);
    endfunction

    // zero-extended little-endian word from the shadow bytes
    function automatic wordT refRead(input addrT addr, input lenT len);
        wordT w;
        addrT b;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            b = addr + addrT'(i);
            w[8*i +: 8] = shadow[b[7:0]];
        end
        return w;
    endfunction

    task automatic writeShadow(input addrT addr, input lenT len, input wordT data);
        addrT b;
        for (int i = 0; i < int'(len); i++) begin
            b = addr + addrT'(i);
            shadow[b[7:0]] = data[8*i +: 8];
        end
    endtask

    task automatic failNow();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            failNow();
        end
    endtask

    task automatic checkAddr(input string name, input addrT expected, input addrT actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            failNow();
        end
    endtask

    // RAM port must stay quiet and steady while stalled
    always @(posedge clk) begin
        if (!rst) begin
            if (memRw == MEM_WRITE && !(rdy && !ioBufferFull)) begin
                $display("error: RAM write while a stall input is active");
                failNow();
            end
            if (!(rdy && !ioBufferFull)) begin
                checkAddr("address during stall", prevAddr, memAddr);
            end
        end
        prevAddr = memAddr;
    end

    // each requester holds its enable until its done pulse
    task automatic runAccess(input logic withInf, input addrT iAddr, input logic withDc,
                             input logic store, input lenT len, input addrT dAddr,
                             input wordT wdata, output wordT iGot, output wordT dGot,
                             output int iAt, output int dAt);
        int   waited;
        logic infBusy;
        logic dcBusy;
        logic adv;
        infBusy = withInf;
        dcBusy  = withDc;
        waited  = 0;
        iGot    = '0;
        dGot    = '0;
        iAt     = 0;
        dAt     = 0;
        @(posedge clk);
        infEn   <= withInf;
        infAddr <= iAddr;
        dcEn    <= withDc;
        dcStore <= store;
        dcLen   <= len;
        dcAddr  <= dAddr;
        dcDt    <= wdata;
        while (infBusy || dcBusy) begin
            @(posedge clk);
            waited++;
            adv = rdy && !ioBufferFull;
            if (adv && ((infDone && !infBusy) || (dcDone && !dcBusy))) begin
                $display("error: done pulse for a requester with nothing in flight");
                failNow();
            end
            if (adv && infBusy && infDone) begin
                infBusy = 1'b0;
                infEn  <= 1'b0;
                iGot    = infInst;
                iAt     = waited;
            end
            if (adv && dcBusy && dcDone) begin
                dcBusy = 1'b0;
                dcEn  <= 1'b0;
                dGot   = dcRdata;
                dAt    = waited;
            end
            if (stallMode) begin
                rdy          <= (randWord() % 4) != 0;
                ioBufferFull <= (randWord() % 5) == 0;
            end
            if (waited > WAIT_LIMIT) begin
                $display("error: request not done after %0d cycles", WAIT_LIMIT);
                failNow();
            end
        end
        rdy          <= 1'b1;
        ioBufferFull <= 1'b0;
    endtask

    task automatic checkedAccess(input string name, input logic withInf, input addrT iAddr,
                                 input logic withDc, input logic store, input lenT len,
                                 input addrT dAddr, input wordT wdata, input logic timeFetch);
        wordT iGot;
        wordT dGot;
        int   iAt;
        int   dAt;
        runAccess(withInf, iAddr, withDc, store, len, dAddr, wdata, iGot, dGot, iAt, dAt);
        if (withDc && store) begin
            checkWord($sformatf("%s store word", name), '0, dGot);
            writeShadow(dAddr, len, wdata);
        end else if (withDc) begin
            checkWord($sformatf("%s load len %0d", name, len), refRead(dAddr, len), dGot);
        end
        // a fetch issued with a data access runs after it and sees any store
        if (withInf) begin
            checkWord($sformatf("%s fetch", name), refRead(iAddr, FETCH_LEN), iGot);
        end
        if (withInf && withDc && !(dAt < iAt)) begin
            $display("mismatch %s order expected data first actual data %0d fetch %0d",
                     name, dAt, iAt);
            failNow();
        end
        if (timeFetch && iAt != 7) begin
            $display("mismatch %s latency expected 7 actual %0d", name, iAt);
            failNow();
        end
    endtask

    initial begin
        lcgState     = 32'd49515;
        stallMode    = 1'b0;
        prevAddr     = '0;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        infEn        = 1'b0;
        infAddr      = '0;
        dcEn         = 1'b0;
        dcStore      = 1'b0;
        dcLen        = 3'd4;
        dcDt         = '0;
        dcAddr       = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        if (infDone || dcDone || memRw == MEM_WRITE) begin
            $display("error: done or write level not cleared by reset");
            failNow();
        end
        checkWord("reset inst", '0, infInst);
        checkWord("reset data", '0, dcRdata);
        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
            if (infDone || dcDone) begin
                $display("error: done pulse seen with no request");
                failNow();
            end
        end
        for (int i = 0; i < 256; i++) begin
            shadow[i] = u_ram.mem[i];
        end

        for (int n = 0; n < 3; n++) begin
            checkedAccess("fetch", 1'b1, randWord(), 1'b0, 1'b0, FETCH_LEN, '0, '0, 1'b1);
        end
        // lengths 1, 2, 4 in turn
        for (int n = 0; n < 6; n++) begin
            checkedAccess("load", 1'b0, '0, 1'b1, 1'b0, lenT'(1 << (n % 3)), randWord(), '0,
                          1'b0);
        end
        for (int n = 0; n < 6; n++) begin
            a = randWord();
            checkedAccess("store", 1'b0, '0, 1'b1, 1'b1, lenT'(1 << (n % 3)), a, randWord(),
                          1'b0);
            checkedAccess("reload", 1'b0, '0, 1'b1, 1'b0, 3'd4, a - addrT'(1), '0, 1'b0);
            checkedAccess("reload high", 1'b0, '0, 1'b1, 1'b0, 3'd4, a + addrT'(1), '0, 1'b0);
        end
        checkedAccess("both load", 1'b1, randWord(), 1'b1, 1'b0, 3'd4, randWord(), '0, 1'b0);
        a = randWord();
        checkedAccess("both store", 1'b1, a, 1'b1, 1'b1, 3'd2, a + addrT'(1), randWord(), 1'b0);

        // mixed traffic with random stalls
        stallMode = 1'b1;
        for (int n = 0; n < 40; n++) begin
            case (randWord() % 4)
                0: checkedAccess("stall fetch", 1'b1, randWord(), 1'b0, 1'b0, FETCH_LEN, '0,
                                 '0, 1'b0);
                1: checkedAccess("stall load", 1'b0, '0, 1'b1, 1'b0,
                                 lenT'(1 << (randWord() % 3)), randWord(), '0, 1'b0);
                2: checkedAccess("stall store", 1'b0, '0, 1'b1, 1'b1,
                                 lenT'(1 << (randWord() % 3)), randWord(), randWord(), 1'b0);
                default: checkedAccess("stall both", 1'b1, randWord(), 1'b1, randWord() % 2 == 0,
                                       lenT'(1 << (randWord() % 3)), randWord(), randWord(),
                                       1'b0);
            endcase
        end
        stallMode = 1'b0;

        $display("** PASS **");
        $finish;
    end

endmodule
